/* src/fx3_pkg.sv */
package fx3_pkg;

    // FX3 slave FIFO bus, 16-bit mode
    // the upper half of the 32-bit bus is not used
    localparam int DATA_W = 16;

    // socket address pins A1..A0
    localparam int ADDR_W = 2;

    // out-endpoint socket, host to FPGA
    // read while SLOE and SLRD are low
    localparam logic [ADDR_W-1:0] ADDR_STREAM_OUT = 2'd3;

    // in-endpoint socket, FPGA to host
    // also the parked address while idle
    localparam logic [ADDR_W-1:0] ADDR_STREAM_IN = 2'd0;

    // cycles from SLRD low, as the FX3 samples it,
    // until the word is valid at the FPGA input register
    // 2 for the FX3 at 100 MHz in synchronous mode
    localparam int READ_LATENCY = 2;

    // flag usage, all active high as configured in firmware
    //   flaga  in-endpoint has space
    //   flagb  in-endpoint above watermark, pause writing
    //   flagc  out-endpoint holds a full block
    //   flagd  out-endpoint may be read now
    // strobes SLCS, SLRD, SLOE, SLWR are active low

endpackage

/* src/xfer_pkg.sv */
package xfer_pkg;

    // words per block in each direction
    // reduced from the 4096 of the board build
    localparam int BLOCK_WORDS = 64;

    // counters must reach BLOCK_WORDS itself
    localparam int CNT_W = $clog2(BLOCK_WORDS + 1);

    // buffer address width
    localparam int PTR_W = $clog2(BLOCK_WORDS);

    // master mode
    // idle: chip not selected, waiting for flagc
    // stream-out: read one block from the out-endpoint
    // stream-in: write the stored block to the in-endpoint
    typedef enum logic [1:0] {
        MODE_IDLE       = 2'd0,
        MODE_STREAM_OUT = 2'd1,
        MODE_STREAM_IN  = 2'd2
    } master_mode_t;

    // encoding 2'd3 is unused, the FSM falls back to idle

endpackage

/* src/loop_buffer.sv */
module loop_buffer (
    input  logic                        usb_clk,
    input  logic                        reset_,
    input  logic                        push_i,
    input  logic [fx3_pkg::DATA_W-1:0]  push_data_i,
    input  logic                        pop_i,
    output logic [fx3_pkg::DATA_W-1:0]  pop_data_o,
    output logic                        empty_o
);

    // one block of storage
    logic [fx3_pkg::DATA_W-1:0] mem [xfer_pkg::BLOCK_WORDS];

    logic [xfer_pkg::PTR_W-1:0] wr_ptr_q;
    logic [xfer_pkg::PTR_W-1:0] rd_ptr_q;
    // words held, 0..BLOCK_WORDS
    logic [xfer_pkg::CNT_W-1:0] count_q;

    // pointer wrap for any depth
    logic wr_wrap;
    logic rd_wrap;

    assign wr_wrap = (wr_ptr_q == xfer_pkg::PTR_W'(xfer_pkg::BLOCK_WORDS - 1));
    assign rd_wrap = (rd_ptr_q == xfer_pkg::PTR_W'(xfer_pkg::BLOCK_WORDS - 1));

    // storage write
    always_ff @(posedge usb_clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers and fill level
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_wrap ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_wrap ? '0 : rd_ptr_q + 1'b1;
            end
            // push and pop together leave the level unchanged
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // show-ahead, head word valid whenever not empty
    assign pop_data_o = mem[rd_ptr_q];
    assign empty_o    = (count_q == '0);

endmodule

/* src/fx3_stream_out_reader.sv */
module fx3_stream_out_reader (
    input  logic                        usb_clk,
    input  logic                        reset_,
    input  logic                        out_start_i,
    input  logic                        flagd_i,
    input  logic [fx3_pkg::DATA_W-1:0]  fdata_i,
    output logic                        rd_req_o,
    output logic                        push_o,
    output logic [fx3_pkg::DATA_W-1:0]  push_data_o,
    output logic                        out_done_o
);

    logic                               flagd_q;
    logic                               busy_q;
    // reads issued and words captured
    logic [xfer_pkg::CNT_W-1:0]         rd_cnt_q;
    logic [xfer_pkg::CNT_W-1:0]         push_cnt_q;
    // mirrors the controller's SLRD pin register
    logic                               rd_pin_q;
    // one bit per cycle of FX3 read latency
    logic [fx3_pkg::READ_LATENCY-1:0]   valid_sr_q;
    logic                               push_q;
    logic [fx3_pkg::DATA_W-1:0]         fdata_q;
    logic                               done_q;
    logic                               rd_all;
    logic                               last_push;

    assign rd_all    = (rd_cnt_q == xfer_pkg::CNT_W'(xfer_pkg::BLOCK_WORDS));
    assign last_push = push_q &&
                       (push_cnt_q == xfer_pkg::CNT_W'(xfer_pkg::BLOCK_WORDS - 1));

    // request while flagd allows and the block is not fully issued
    assign rd_req_o = busy_q && flagd_q && !rd_all;

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flagd_q    <= 1'b0;
            busy_q     <= 1'b0;
            rd_cnt_q   <= '0;
            push_cnt_q <= '0;
            rd_pin_q   <= 1'b0;
            valid_sr_q <= '0;
            push_q     <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            flagd_q  <= flagd_i;
            rd_pin_q <= rd_req_o;
            // slrd sampled by FX3, then the latency pipeline
            valid_sr_q[0] <= rd_pin_q;
            for (int i = 1; i < fx3_pkg::READ_LATENCY; i++) begin
                valid_sr_q[i] <= valid_sr_q[i-1];
            end
            // tag matches the word landing in fdata_q
            push_q <= valid_sr_q[fx3_pkg::READ_LATENCY-1];
            done_q <= last_push;
            if (out_start_i) begin
                busy_q     <= 1'b1;
                rd_cnt_q   <= '0;
                push_cnt_q <= '0;
            end else begin
                if (rd_req_o) begin
                    rd_cnt_q <= rd_cnt_q + 1'b1;
                end
                if (push_q) begin
                    push_cnt_q <= push_cnt_q + 1'b1;
                end
                // in-flight words drain before busy drops
                if (last_push) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // input register on the FX3 data bus
    always_ff @(posedge usb_clk) begin
        fdata_q <= fdata_i;
    end

    assign push_o      = push_q;
    assign push_data_o = fdata_q;
    // one cycle after the last push
    assign out_done_o  = done_q;

endmodule

/* src/fx3_stream_in_writer.sv */
module fx3_stream_in_writer (
    input  logic                        usb_clk,
    input  logic                        reset_,
    input  logic                        in_start_i,
    input  logic                        flaga_i,
    input  logic                        flagb_i,
    input  logic                        empty_i,
    input  logic [fx3_pkg::DATA_W-1:0]  pop_data_i,
    output logic                        pop_o,
    output logic                        wr_req_o,
    output logic [fx3_pkg::DATA_W-1:0]  wr_data_o,
    output logic                        in_done_o
);

    logic                       flaga_q;
    logic                       flagb_q;
    logic                       busy_q;
    // write requests issued this block
    logic [xfer_pkg::CNT_W-1:0] wr_cnt_q;
    logic                       done_q;
    logic                       flags_ok;
    logic                       last_wr;

    // space available and below watermark
    assign flags_ok = flaga_q && !flagb_q;

    assign wr_req_o = busy_q && flags_ok && !empty_i;
    assign last_wr  = wr_req_o &&
                      (wr_cnt_q == xfer_pkg::CNT_W'(xfer_pkg::BLOCK_WORDS - 1));

    // every write consumes the head word
    assign pop_o     = wr_req_o;
    assign wr_data_o = pop_data_i;

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flaga_q  <= 1'b0;
            flagb_q  <= 1'b0;
            busy_q   <= 1'b0;
            wr_cnt_q <= '0;
            done_q   <= 1'b0;
        end else begin
            flaga_q <= flaga_i;
            flagb_q <= flagb_i;
            done_q  <= last_wr;
            if (in_start_i) begin
                busy_q   <= 1'b1;
                wr_cnt_q <= '0;
            end else if (wr_req_o) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
                // stop right after the last request
                if (last_wr) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // pulse in the cycle SLWR shows the last word
    assign in_done_o = done_q;

endmodule

/* src/fx3_mode_ctrl.sv */
module fx3_mode_ctrl (
    input  logic                        usb_clk,
    input  logic                        reset_,
    input  logic                        flagc_i,
    input  logic                        rd_req_i,
    input  logic                        wr_req_i,
    input  logic [fx3_pkg::DATA_W-1:0]  wr_data_i,
    input  logic                        out_done_i,
    input  logic                        in_done_i,
    output logic                        out_start_o,
    output logic                        in_start_o,
    output logic                        slcs_o,
    output logic                        slrd_o,
    output logic                        sloe_o,
    output logic                        slwr_o,
    output logic [fx3_pkg::ADDR_W-1:0]  fifo_addr_o,
    output logic [fx3_pkg::DATA_W-1:0]  fdata_o,
    output logic                        fdata_oe_o
);

    xfer_pkg::master_mode_t mode_q;
    xfer_pkg::master_mode_t mode_next;

    logic flagc_q;
    logic out_start_next;
    logic in_start_next;
    // strobes gated by the owning mode
    logic rd_strobe;
    logic wr_strobe;

    // mode sequencing
    always_comb begin
        mode_next      = mode_q;
        out_start_next = 1'b0;
        in_start_next  = 1'b0;
        case (mode_q)
            xfer_pkg::MODE_IDLE: begin
                // full block waiting in the out-endpoint
                if (flagc_q) begin
                    mode_next      = xfer_pkg::MODE_STREAM_OUT;
                    out_start_next = 1'b1;
                end
            end
            xfer_pkg::MODE_STREAM_OUT: begin
                // last word stored, send it back
                if (out_done_i) begin
                    mode_next     = xfer_pkg::MODE_STREAM_IN;
                    in_start_next = 1'b1;
                end
            end
            xfer_pkg::MODE_STREAM_IN: begin
                if (in_done_i) begin
                    mode_next = xfer_pkg::MODE_IDLE;
                end
            end
            default: begin
                mode_next = xfer_pkg::MODE_IDLE;
            end
        endcase
    end

    assign rd_strobe = rd_req_i && (mode_q == xfer_pkg::MODE_STREAM_OUT);
    assign wr_strobe = wr_req_i && (mode_q == xfer_pkg::MODE_STREAM_IN);

    // state, start pulses and pin registers
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            mode_q      <= xfer_pkg::MODE_IDLE;
            flagc_q     <= 1'b0;
            out_start_o <= 1'b0;
            in_start_o  <= 1'b0;
            slcs_o      <= 1'b1;
            slrd_o      <= 1'b1;
            sloe_o      <= 1'b1;
            slwr_o      <= 1'b1;
            fifo_addr_o <= fx3_pkg::ADDR_STREAM_IN;
            fdata_oe_o  <= 1'b0;
        end else begin
            flagc_q     <= flagc_i;
            mode_q      <= mode_next;
            out_start_o <= out_start_next;
            in_start_o  <= in_start_next;
            // chip selected outside idle
            slcs_o      <= (mode_next == xfer_pkg::MODE_IDLE);
            slrd_o      <= !rd_strobe;
            // output enable held for the whole read phase
            sloe_o      <= (mode_next != xfer_pkg::MODE_STREAM_OUT);
            slwr_o      <= !wr_strobe;
            // in-endpoint address doubles as the parked one
            if (mode_next == xfer_pkg::MODE_STREAM_OUT) begin
                fifo_addr_o <= fx3_pkg::ADDR_STREAM_OUT;
            end else begin
                fifo_addr_o <= fx3_pkg::ADDR_STREAM_IN;
            end
            // drive the bus only while writing the block
            fdata_oe_o  <= (mode_next == xfer_pkg::MODE_STREAM_IN);
        end
    end

    // write data, aligned with slwr_o
    always_ff @(posedge usb_clk) begin
        if (wr_strobe) begin
            fdata_o <= wr_data_i;
        end
    end

endmodule

/* src/fx3_loopback_top.sv */
module fx3_loopback_top (
    input  logic                        usb_clk,
    input  logic                        reset_,
    // FX3 control strobes, active low
    output logic                        slcs_o,
    output logic                        slrd_o,
    output logic                        sloe_o,
    output logic                        slwr_o,
    output logic [fx3_pkg::ADDR_W-1:0]  fifo_addr_o,
    output logic [fx3_pkg::DATA_W-1:0]  fdata_o,
    output logic                        fdata_oe_o,
    // FX3 flags and read data
    input  logic                        flaga_i,
    input  logic                        flagb_i,
    input  logic                        flagc_i,
    input  logic                        flagd_i,
    input  logic [fx3_pkg::DATA_W-1:0]  fdata_i
);

    logic                       out_start;
    logic                       in_start;
    logic                       out_done;
    logic                       in_done;
    logic                       rd_req;
    logic                       wr_req;
    logic [fx3_pkg::DATA_W-1:0] wr_data;
    // buffer traffic
    logic                       push;
    logic [fx3_pkg::DATA_W-1:0] push_data;
    logic                       pop;
    logic [fx3_pkg::DATA_W-1:0] pop_data;
    logic                       empty;

    fx3_mode_ctrl ctrl_i (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flagc_i     (flagc_i),
        .rd_req_i    (rd_req),
        .wr_req_i    (wr_req),
        .wr_data_i   (wr_data),
        .out_done_i  (out_done),
        .in_done_i   (in_done),
        .out_start_o (out_start),
        .in_start_o  (in_start),
        .slcs_o      (slcs_o),
        .slrd_o      (slrd_o),
        .sloe_o      (sloe_o),
        .slwr_o      (slwr_o),
        .fifo_addr_o (fifo_addr_o),
        .fdata_o     (fdata_o),
        .fdata_oe_o  (fdata_oe_o)
    );

    fx3_stream_out_reader reader_i (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .out_start_i (out_start),
        .flagd_i     (flagd_i),
        .fdata_i     (fdata_i),
        .rd_req_o    (rd_req),
        .push_o      (push),
        .push_data_o (push_data),
        .out_done_o  (out_done)
    );

    fx3_stream_in_writer writer_i (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .in_start_i (in_start),
        .flaga_i    (flaga_i),
        .flagb_i    (flagb_i),
        .empty_i    (empty),
        .pop_data_i (pop_data),
        .pop_o      (pop),
        .wr_req_o   (wr_req),
        .wr_data_o  (wr_data),
        .in_done_o  (in_done)
    );

    loop_buffer buffer_i (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (empty)
    );

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic usb_clk,
    output logic reset_
);

    // free running clock, period 2*HALF_PERIOD
    initial begin
        usb_clk = 1'b0;
        forever #HALF_PERIOD usb_clk = ~usb_clk;
    end

    // reset held low, released just after a rising edge
    initial begin
        reset_ = 1'b0;
        repeat (RESET_CYCLES) @(posedge usb_clk);
        #1 reset_ = 1'b1;
    end

endmodule

/* sim/fx3_loopback_checker.sv */
module fx3_loopback_checker (
    input  logic usb_clk,
    input  logic reset_,
    input  logic slcs_i,
    input  logic slrd_i,
    input  logic slwr_i,
    input  logic fdata_oe_i
);

    // failed assertions so far, read by the testbench
    int fail_count = 0;

    // one direction at a time on the shared bus
    rd_wr_exclusive: assert property (
        @(posedge usb_clk) disable iff (!reset_)
        !(!slrd_i && !slwr_i)
    ) else begin
        $error("slrd and slwr are low in the same cycle");
        fail_count++;
    end

    // write data must be driven when the FX3 samples it
    wr_drives_bus: assert property (
        @(posedge usb_clk) disable iff (!reset_)
        !slwr_i |-> fdata_oe_i
    ) else begin
        $error("slwr is low while fdata_oe is low");
        fail_count++;
    end

    // FX3 ignores strobes without chip select
    strobe_needs_cs: assert property (
        @(posedge usb_clk) disable iff (!reset_)
        (!slrd_i || !slwr_i) |-> !slcs_i
    ) else begin
        $error("read or write strobe while slcs is high");
        fail_count++;
    end

endmodule

bind fx3_loopback_top fx3_loopback_checker checker_i (
    .usb_clk    (usb_clk),
    .reset_     (reset_),
    .slcs_i     (slcs_o),
    .slrd_i     (slrd_o),
    .slwr_i     (slwr_o),
    .fdata_oe_i (fdata_oe_o)
);

/* sim/fx3_loopback_tb.sv */
module fx3_loopback_tb;

    localparam int BW          = xfer_pkg::BLOCK_WORDS;
    localparam int LAT         = fx3_pkg::READ_LATENCY;
    localparam int DW          = fx3_pkg::DATA_W;
    localparam int NUM_BLOCKS  = 6;
    localparam int DRIVE_DELAY = 1;
    // cycle limits of the waits
    localparam int RESET_LIMIT = 64;
    localparam int BLOCK_LIMIT = 50 * BW;
    localparam int IDLE_LIMIT  = 16;

    logic          usb_clk;
    logic          reset_;
    logic          slcs_o;
    logic          slrd_o;
    logic          sloe_o;
    logic          slwr_o;
    logic [1:0]    fifo_addr_o;
    logic [DW-1:0] fdata_o;
    logic          fdata_oe_o;
    logic          flaga_i;
    logic          flagb_i;
    logic          flagc_i;
    logic          flagd_i;
    logic [DW-1:0] fdata_i;

    integer seed = 32'h3e03_4fee;
    // block words in the order the FX3 hands them out
    logic [DW-1:0] stream [NUM_BLOCKS * BW];
    int            blocks_loaded;
    int            read_count;
    int            write_count;
    bit            rand_out;
    bit            rand_in;
    // flags as sampled at the last three edges, [2] is oldest
    logic [2:0]    flagd_hist;
    logic [2:0]    flaga_hist;
    logic [2:0]    flagb_hist;
    logic [DW-1:0] rd_pipe [LAT-1];
    logic [DW-1:0] wr_q [$];
    logic          rd_seen;
    logic          wr_seen;
    logic [DW-1:0] rd_word;
    logic [DW-1:0] wr_word;

    tb_clock_gen clk_gen_i (.usb_clk(usb_clk), .reset_(reset_));

    fx3_loopback_top dut_i (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .slcs_o      (slcs_o),
        .slrd_o      (slrd_o),
        .sloe_o      (sloe_o),
        .slwr_o      (slwr_o),
        .fifo_addr_o (fifo_addr_o),
        .fdata_o     (fdata_o),
        .fdata_oe_o  (fdata_oe_o),
        .flaga_i     (flaga_i),
        .flagb_i     (flagb_i),
        .flagc_i     (flagc_i),
        .flagd_i     (flagd_i),
        .fdata_i     (fdata_i)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        string msg;
        assert (got === exp) else begin
            msg = $sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error(msg);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else stop_on_error(what);
    endtask

    // loopback is the identity, write n of block b is read n of block b
    function automatic logic [DW-1:0] expected_word(input int blk, input int n);
        return stream[blk * BW + n];
    endfunction

    task automatic check_idle_pins();
        check_value("slcs_o", slcs_o, 1'b1);
        check_value("slrd_o", slrd_o, 1'b1);
        check_value("sloe_o", sloe_o, 1'b1);
        check_value("slwr_o", slwr_o, 1'b1);
        check_value("fdata_oe_o", fdata_oe_o, 1'b0);
        check_value("fifo_addr_o", fifo_addr_o, fx3_pkg::ADDR_STREAM_IN);
    endtask

    // FX3 model, pins as they stood just before the edge
    always @(posedge usb_clk) begin
        rd_seen    = reset_ && !slrd_o;
        wr_seen    = reset_ && !slwr_o;
        flagd_hist = {flagd_hist[1:0], flagd_i};
        flaga_hist = {flaga_hist[1:0], flaga_i};
        flagb_hist = {flagb_hist[1:0], flagb_i};
        if (rd_seen) begin
            check_true(!slcs_o && !sloe_o, "read strobe without chip select or output enable");
            check_value("fifo_addr_o", fifo_addr_o, fx3_pkg::ADDR_STREAM_OUT);
            check_value("fdata_oe_o", fdata_oe_o, 1'b0);
            // two register stages between flagd and the pin
            check_true(flagd_hist[2], "read issued although flagd was low");
            check_true(read_count < blocks_loaded * BW, "read issued with no word left");
            rd_word = stream[read_count];
            read_count++;
        end
        if (wr_seen) begin
            check_true(!slcs_o && slrd_o, "write strobe without chip select or during a read");
            check_value("fdata_oe_o", fdata_oe_o, 1'b1);
            check_value("fifo_addr_o", fifo_addr_o, fx3_pkg::ADDR_STREAM_IN);
            check_true(flaga_hist[2] && !flagb_hist[2], "write issued while the flags forbid it");
            wr_q.push_back(fdata_o);
        end
        #DRIVE_DELAY;
        // read data lands READ_LATENCY edges after the sampling edge
        fdata_i = rd_pipe[LAT-2];
        for (int i = LAT - 2; i > 0; i--) begin
            rd_pipe[i] = rd_pipe[i-1];
        end
        // junk on the bus in cycles that carry no word
        rd_pipe[0] = rd_seen ? rd_word : DW'($random(seed));
        flagc_i = (blocks_loaded * BW >= read_count + BW);
        flagd_i = rand_out ? 1'($random(seed)) : 1'b1;
        flaga_i = rand_in ? 1'($random(seed)) : 1'b1;
        flagb_i = rand_in ? (($random(seed) & 3) == 0) : 1'b0;
    end

    // compares recorded writes against the reference
    always @(negedge usb_clk) begin
        check_true(dut_i.checker_i.fail_count == 0, "a pin protocol assertion failed");
        while (wr_q.size() > 0) begin
            wr_word = wr_q.pop_front();
            check_true(write_count < blocks_loaded * BW, "write issued with no block to return");
            check_value("fdata_o", wr_word, expected_word(write_count / BW, write_count % BW));
            write_count++;
        end
    end

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (reset_ !== 1'b1) begin
            @(posedge usb_clk);
            cycles++;
            if (cycles > RESET_LIMIT) stop_on_error("reset was never released");
        end
    endtask

    task automatic wait_for_writes(input int target);
        int cycles;
        cycles = 0;
        while (write_count < target) begin
            @(posedge usb_clk);
            cycles++;
            if (cycles > BLOCK_LIMIT) stop_on_error("timeout, block was not written back");
        end
    endtask

    task automatic wait_for_idle();
        int cycles;
        cycles = 0;
        while (slcs_o !== 1'b1) begin
            @(posedge usb_clk);
            cycles++;
            if (cycles > IDLE_LIMIT) stop_on_error("timeout, DUT did not return to idle");
        end
    endtask

    // one block through the out-endpoint and back
    task automatic run_block(input bit toggle_out, input bit toggle_in);
        int target;
        target = (blocks_loaded + 1) * BW;
        @(negedge usb_clk);
        rand_out = toggle_out;
        rand_in  = toggle_in;
        for (int i = 0; i < BW; i++) begin
            stream[blocks_loaded * BW + i] = DW'($random(seed));
        end
        blocks_loaded++;
        wait_for_writes(target);
        wait_for_idle();
        // nothing more may move once idle
        repeat (4) @(posedge usb_clk);
        check_idle_pins();
        check_value("read_count", read_count, target);
        check_value("write_count", write_count, target);
    endtask

    initial begin
        flaga_i       = 1'b0;
        flagb_i       = 1'b0;
        flagc_i       = 1'b0;
        flagd_i       = 1'b0;
        fdata_i       = '0;
        flagd_hist    = '0;
        flaga_hist    = '0;
        flagb_hist    = '0;
        blocks_loaded = 0;
        read_count    = 0;
        write_count   = 0;
        rand_out      = 1'b0;
        rand_in       = 1'b0;
        foreach (rd_pipe[i]) rd_pipe[i] = '0;
        wait_for_reset();
        // quiet pins while no block is offered
        repeat (20) begin
            @(posedge usb_clk);
            check_idle_pins();
        end
        run_block(1'b0, 1'b0);
        run_block(1'b1, 1'b0);
        run_block(1'b0, 1'b1);
        // back to back, all flags toggling
        for (int b = 0; b < 3; b++) begin
            run_block(1'b1, 1'b1);
        end
        // let the assertions of the last edge settle
        @(negedge usb_clk);
        if (dut_i.checker_i.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "pin protocol assertion failed");
        end
    end

endmodule

/* flist.f */
src/fx3_pkg.sv
src/xfer_pkg.sv
src/loop_buffer.sv
src/fx3_stream_out_reader.sv
src/fx3_stream_in_writer.sv
src/fx3_mode_ctrl.sv
src/fx3_loopback_top.sv
sim/tb_clock_gen.sv
sim/fx3_loopback_checker.sv
sim/fx3_loopback_tb.sv
